// ==== hdl/fdc_reg_pkg.sv ====
// ==============================
// fdc register definitions
// data byte type, main status bit
// positions and status 0 codes
// ==============================

package fdc_reg_pkg;

	// one byte on the host data bus or in a register
	typedef logic [7:0] reg_byte_t;

	// ==============================
	// main status register
	// ==============================
	localparam int MSR_D0B = 0;	// drive 0 seeking
	localparam int MSR_D1B = 1;	// drive 1 seeking
	localparam int MSR_CB  = 4;	// controller busy
	localparam int MSR_DIO = 6;	// 1 = controller to host
	localparam int MSR_RQM = 7;	// data port ready

	localparam reg_byte_t MSR_RESET = 8'h80;	// only rqm set

	// ==============================
	// status register 0 replies
	// ==============================

	// normal end of seek, drive number goes into bit 0
	localparam reg_byte_t ST0_SEEK_END = 8'h20;

	// abnormal end, seek end and not ready
	localparam reg_byte_t ST0_SEEK_FAIL = 8'hE8;

	// invalid opcode, also sense int with nothing pending
	localparam reg_byte_t ST0_INVALID = 8'h80;

endpackage

// ==== hdl/fdc_cmd_pkg.sv ====
// ==============================
// fdc command definitions
// opcodes, command phases, drive and
// cylinder types, drive limits
// ==============================

package fdc_cmd_pkg;

	// kept commands by their low five opcode bits
	// upper three bits of the opcode byte must be zero
	typedef enum logic [4:0] {
		OP_SPECIFY     = 5'h03,
		OP_SENSE_DRIVE = 5'h04,
		OP_RECALIBRATE = 5'h07,
		OP_SENSE_INT   = 5'h08,
		OP_SEEK        = 5'h0F
	} fdc_opcode_e;

	// command machine phases
	typedef enum logic [2:0] {
		PH_IDLE,	// waiting for an opcode
		PH_SPEC_SRT,	// specify byte 1, srt and hut
		PH_SPEC_HLT,	// specify byte 2, hlt and nd
		PH_UNIT,	// drive select byte
		PH_NCN,	// seek target cylinder
		PH_RESULT	// reply bytes to the host
	} fdc_phase_e;

	// drive select, two drives
	typedef logic drive_t;

	// cylinder number
	typedef logic [7:0] cyl_t;

	// step rate field of specify
	typedef logic [3:0] step_rate_t;

	// ==============================
	// drive limits
	// ==============================

	// cylinders on a drive
	localparam cyl_t MAX_TRACKS = 8'd80;

	// step rate until the first specify
	localparam step_rate_t SRT_RESET = 4'd4;

endpackage

// ==== hdl/fdc_host_port.sv ====
// ==============================
// fdc host port
// samples the bus strobes, makes data port
// pulses and drives the read data byte
// ==============================

module fdc_host_port (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  logic                   i_nrd,
	input  logic                   i_nwr,
	input  logic                   i_a0,
	input  fdc_reg_pkg::reg_byte_t i_din,
	input  fdc_reg_pkg::reg_byte_t i_result,
	input  logic                   i_rqm,
	input  logic                   i_dio,
	input  logic                   i_cb,
	input  logic [1:0]             i_drive_busy,
	output logic                   o_data_wr,
	output logic                   o_data_rd,
	output fdc_reg_pkg::reg_byte_t o_wr_byte,
	output fdc_reg_pkg::reg_byte_t o_dout
);
	import fdc_reg_pkg::*;

	logic      nrd_s, nwr_s, a0_s;	// sampled pins
	logic      rd_old, wr_old;	// previous sample
	logic      rd_s, wr_s;
	logic      stat_rd;	// main status read pulse
	reg_byte_t msr, msr_next;

	assign rd_s = nwr_s & ~nrd_s;
	assign wr_s = ~nwr_s & nrd_s;

	// main status from the command machine and the seek units
	always_comb begin
		msr_next = '0;
		msr_next[MSR_D0B] = i_drive_busy[0];
		msr_next[MSR_D1B] = i_drive_busy[1];
		msr_next[MSR_CB]  = i_cb;
		msr_next[MSR_DIO] = i_dio;
		msr_next[MSR_RQM] = i_rqm;
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			nrd_s     <= 1'b1;
			nwr_s     <= 1'b1;
			a0_s      <= 1'b0;
			rd_old    <= 1'b0;
			wr_old    <= 1'b0;
			o_data_wr <= 1'b0;
			o_data_rd <= 1'b0;
			stat_rd   <= 1'b0;
			msr       <= MSR_RESET;
			o_dout    <= '0;
		end else begin
			nrd_s  <= i_nrd;
			nwr_s  <= i_nwr;
			a0_s   <= i_a0;
			rd_old <= rd_s;
			wr_old <= wr_s;
			// a0 decoded once here, status reads stay local
			o_data_wr <= wr_s & ~wr_old & a0_s;
			o_data_rd <= rd_s & ~rd_old & a0_s;
			stat_rd   <= rd_s & ~rd_old & ~a0_s;
			msr       <= msr_next;
			if (stat_rd)
				o_dout <= msr;
			else if (o_data_rd)
				o_dout <= i_result;	// reply byte before the fsm advances
		end
	end

	// written byte, taken once per write strobe
	always_ff @(posedge clk_sys) begin
		if (wr_s & ~wr_old)
			o_wr_byte <= i_din;
	end

endmodule

// ==== hdl/fdc_drive_seek.sv ====
// ==============================
// fdc seek unit, one per drive
// head position, step timer and
// interrupt pending state
// ==============================

module fdc_drive_seek #(
	parameter int CYCLES_PER_MS = 4000
) (
	input  logic                    clk_sys,
	input  logic                    reset,
	input  logic                    i_seek_start,
	input  fdc_cmd_pkg::cyl_t       i_target_cyl,
	input  fdc_cmd_pkg::step_rate_t i_step_rate,
	input  logic                    i_ready,
	input  logic                    i_int_clear,
	output fdc_cmd_pkg::cyl_t       o_pcn,
	output logic                    o_busy,
	output logic                    o_int_pending,
	output logic                    o_int_ok
);
	import fdc_cmd_pkg::*;

	localparam int MS_W = (CYCLES_PER_MS < 2) ? 1 : $clog2(CYCLES_PER_MS + 1);

	typedef enum logic [1:0] {
		SK_IDLE,
		SK_STEP,	// compare and move one cylinder
		SK_WAIT	// step period
	} seek_state_e;

	seek_state_e      state;
	cyl_t             ncn;	// new cylinder number
	logic [MS_W-1:0]  ms_cnt;	// cycles left in this ms
	logic [4:0]       ms_left;	// ms left in this step
	logic             target_ok;

	assign target_ok = (i_ready && (i_target_cyl < MAX_TRACKS)) || (i_target_cyl == '0);
	assign o_busy    = (state != SK_IDLE);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state         <= SK_IDLE;
			o_pcn         <= '0;
			o_int_pending <= 1'b0;
			o_int_ok      <= 1'b0;
			ms_cnt        <= '0;
			ms_left       <= '0;
		end else begin
			if (i_int_clear)
				o_int_pending <= 1'b0;

			case (state)
				SK_IDLE: begin
					if (i_seek_start) begin
						if (target_ok) begin
							ncn           <= i_target_cyl;
							o_int_pending <= 1'b0;
							state         <= SK_STEP;
						end else begin
							o_int_pending <= 1'b1;	// seek error, head stays
							o_int_ok      <= 1'b0;
						end
					end
				end

				SK_STEP: begin
					if (o_pcn == ncn) begin
						o_int_pending <= 1'b1;
						o_int_ok      <= i_ready;
						state         <= SK_IDLE;
					end else begin
						o_pcn   <= (o_pcn < ncn) ? o_pcn + 1'b1 : o_pcn - 1'b1;
						ms_cnt  <= MS_W'(CYCLES_PER_MS);
						ms_left <= 5'd16 - 5'(i_step_rate);	// 16 - srt ms per step
						state   <= SK_WAIT;
					end
				end

				SK_WAIT: begin
					if (ms_cnt != '0) begin
						ms_cnt <= ms_cnt - 1'b1;
					end else if (ms_left != 5'd1) begin
						ms_left <= ms_left - 1'b1;
						ms_cnt  <= MS_W'(CYCLES_PER_MS);
					end else begin
						state <= SK_STEP;
					end
				end

				default: state <= SK_IDLE;
			endcase
		end
	end

endmodule

// ==== hdl/fdc_command_fsm.sv ====
// ==============================
// fdc command machine
// opcode decode, parameter and reply
// phases, specify register
// ==============================

module fdc_command_fsm (
	input  logic                    clk_sys,
	input  logic                    reset,
	input  logic                    i_data_wr,
	input  logic                    i_data_rd,
	input  fdc_reg_pkg::reg_byte_t  i_wr_byte,
	input  fdc_cmd_pkg::cyl_t       i_pcn [2],
	input  logic [1:0]              i_busy,
	input  logic [1:0]              i_int_pending,
	input  logic [1:0]              i_int_ok,
	input  logic [1:0]              i_ready,
	input  logic [1:0]              i_wp,
	input  logic [1:0]              i_two_sided,
	output fdc_reg_pkg::reg_byte_t  o_result,
	output logic                    o_rqm,
	output logic                    o_dio,
	output logic                    o_cb,
	output logic [1:0]              o_seek_start,
	output fdc_cmd_pkg::cyl_t       o_target_cyl,
	output fdc_cmd_pkg::step_rate_t o_step_rate,
	output logic [1:0]              o_int_clear
);
	import fdc_reg_pkg::*;
	import fdc_cmd_pkg::*;

	fdc_phase_e  phase;
	fdc_opcode_e cmd;	// command in progress
	fdc_opcode_e op_dec;
	logic        op_valid;
	drive_t      drv;	// drive of the seek in progress
	drive_t      unit;	// drive in the byte being written
	drive_t      int_sel;	// lowest pending drive
	drive_t      int_drv;
	logic        int_clr_due;	// clear on the final read
	logic        res_more;
	reg_byte_t   res_next;	// second reply byte
	reg_byte_t   int_st0;
	reg_byte_t   st3;

	// ==============================
	// decode and reply bytes
	// ==============================
	always_comb begin
		op_valid = 1'b0;
		op_dec   = OP_SPECIFY;
		if (i_wr_byte[7:5] == 3'b000) begin
			case (i_wr_byte[4:0])
				OP_SPECIFY, OP_SENSE_DRIVE, OP_RECALIBRATE, OP_SENSE_INT, OP_SEEK: begin
					op_valid = 1'b1;
					op_dec   = fdc_opcode_e'(i_wr_byte[4:0]);
				end
				default: op_valid = 1'b0;
			endcase
		end
	end

	assign unit    = i_wr_byte[0];
	assign int_sel = i_int_pending[0] ? 1'b0 : 1'b1;
	assign int_st0 = (i_int_ok[int_sel] ? ST0_SEEK_END : ST0_SEEK_FAIL) | reg_byte_t'(int_sel);

	// st3 for the drive named in the unit byte
	assign st3 = {1'b0,
		i_wp[unit] & i_ready[unit],	// write protect
		i_ready[unit],
		i_pcn[unit] == '0,	// track 0
		i_two_sided[unit],
		i_wr_byte[2],	// head
		1'b0,
		unit};

	// status bits seen by the host
	always_comb begin
		o_rqm = 1'b1;
		o_cb  = 1'b1;
		o_dio = (phase == PH_RESULT);
		if (phase == PH_IDLE) begin
			o_rqm = ~|i_busy;	// no new command while a head moves
			o_cb  = 1'b0;
		end
	end

	// ==============================
	// command phases
	// ==============================
	always_ff @(posedge clk_sys) begin
		o_seek_start <= '0;
		o_int_clear  <= '0;
		if (reset) begin
			phase       <= PH_IDLE;
			cmd         <= OP_SPECIFY;
			o_step_rate <= SRT_RESET;
			o_result    <= '0;
			res_more    <= 1'b0;
			int_clr_due <= 1'b0;
		end else begin
			case (phase)
				PH_IDLE: begin
					if (i_data_wr && !(|i_busy)) begin
						cmd <= op_dec;
						if (!(op_valid && op_dec == OP_SENSE_INT))
							o_int_clear <= 2'b11;
						if (!op_valid) begin
							o_result <= ST0_INVALID;
							res_more <= 1'b0;
							phase    <= PH_RESULT;
						end else if (op_dec == OP_SPECIFY) begin
							phase <= PH_SPEC_SRT;
						end else if (op_dec == OP_SENSE_INT) begin
							if (|i_int_pending) begin
								o_result    <= int_st0;
								res_next    <= i_pcn[int_sel];
								int_drv     <= int_sel;
								res_more    <= 1'b1;
								int_clr_due <= 1'b1;
							end else begin
								o_result <= ST0_INVALID;	// nothing pending
								res_more <= 1'b0;
							end
							phase <= PH_RESULT;
						end else begin
							phase <= PH_UNIT;
						end
					end
				end

				PH_SPEC_SRT: if (i_data_wr) begin
					o_step_rate <= i_wr_byte[7:4];	// hut unused
					phase       <= PH_SPEC_HLT;
				end

				PH_SPEC_HLT: if (i_data_wr)
					phase <= PH_IDLE;	// hlt and nd unused

				PH_UNIT: if (i_data_wr) begin
					drv <= unit;
					if (cmd == OP_SEEK) begin
						phase <= PH_NCN;
					end else if (cmd == OP_RECALIBRATE) begin
						o_seek_start[unit] <= 1'b1;
						o_target_cyl       <= '0;
						phase              <= PH_IDLE;
					end else begin
						o_result <= st3;	// sense drive status
						res_more <= 1'b0;
						phase    <= PH_RESULT;
					end
				end

				PH_NCN: if (i_data_wr) begin
					o_seek_start[drv] <= 1'b1;
					o_target_cyl      <= i_wr_byte;
					phase             <= PH_IDLE;
				end

				PH_RESULT: if (i_data_rd) begin
					if (res_more) begin
						o_result <= res_next;
						res_more <= 1'b0;
					end else begin
						if (int_clr_due)
							o_int_clear[int_drv] <= 1'b1;
						int_clr_due <= 1'b0;
						phase       <= PH_IDLE;
					end
				end

				default: phase <= PH_IDLE;
			endcase
		end
	end

endmodule

// ==== hdl/fdc_top.sv ====
// ==============================
// fdc top level
// host port, command machine and
// one seek unit per drive
// ==============================

module fdc_top #(
	parameter int CYCLES_PER_MS = 4000
) (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  logic                   i_nrd,
	input  logic                   i_nwr,
	input  logic                   i_a0,
	input  fdc_reg_pkg::reg_byte_t i_din,
	input  logic [1:0]             i_ready,
	input  logic [1:0]             i_wp,
	input  logic [1:0]             i_two_sided,
	output fdc_reg_pkg::reg_byte_t o_dout
);
	import fdc_reg_pkg::*;
	import fdc_cmd_pkg::*;

	logic       data_wr, data_rd;
	reg_byte_t  wr_byte, result;
	logic       rqm, dio, cb;
	logic [1:0] seek_start, int_clear;
	logic [1:0] busy, int_pending, int_ok;
	cyl_t       target_cyl;
	cyl_t       pcn [2];
	step_rate_t step_rate;

	fdc_host_port i_host_port (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.i_nrd        (i_nrd),
		.i_nwr        (i_nwr),
		.i_a0         (i_a0),
		.i_din        (i_din),
		.i_result     (result),
		.i_rqm        (rqm),
		.i_dio        (dio),
		.i_cb         (cb),
		.i_drive_busy (busy),
		.o_data_wr    (data_wr),
		.o_data_rd    (data_rd),
		.o_wr_byte    (wr_byte),
		.o_dout       (o_dout)
	);

	fdc_command_fsm i_command_fsm (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.i_data_wr     (data_wr),
		.i_data_rd     (data_rd),
		.i_wr_byte     (wr_byte),
		.i_pcn         (pcn),
		.i_busy        (busy),
		.i_int_pending (int_pending),
		.i_int_ok      (int_ok),
		.i_ready       (i_ready),
		.i_wp          (i_wp),
		.i_two_sided   (i_two_sided),
		.o_result      (result),
		.o_rqm         (rqm),
		.o_dio         (dio),
		.o_cb          (cb),
		.o_seek_start  (seek_start),
		.o_target_cyl  (target_cyl),
		.o_step_rate   (step_rate),
		.o_int_clear   (int_clear)
	);

	fdc_drive_seek #(.CYCLES_PER_MS(CYCLES_PER_MS)) i_seek0 (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.i_seek_start  (seek_start[0]),
		.i_target_cyl  (target_cyl),
		.i_step_rate   (step_rate),
		.i_ready       (i_ready[0]),
		.i_int_clear   (int_clear[0]),
		.o_pcn         (pcn[0]),
		.o_busy        (busy[0]),
		.o_int_pending (int_pending[0]),
		.o_int_ok      (int_ok[0])
	);

	fdc_drive_seek #(.CYCLES_PER_MS(CYCLES_PER_MS)) i_seek1 (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.i_seek_start  (seek_start[1]),
		.i_target_cyl  (target_cyl),
		.i_step_rate   (step_rate),
		.i_ready       (i_ready[1]),
		.i_int_clear   (int_clear[1]),
		.o_pcn         (pcn[1]),
		.o_busy        (busy[1]),
		.o_int_pending (int_pending[1]),
		.o_int_ok      (int_ok[1])
	);

endmodule

// ==== testbench/fdc_props.sv ====
// ==============================
// seek unit assertions
// head movement and interrupt rules
// ==============================

module fdc_props (
	input logic              clk_sys,
	input logic              reset,
	input fdc_cmd_pkg::cyl_t i_pcn,
	input logic              i_busy,
	input logic              i_int_pending
);
	timeunit 1ns;
	timeprecision 100ps;

	import fdc_cmd_pkg::*;

	// head parked at cylinder 0, nothing pending
	a_reset_state: assert property (@(posedge clk_sys)
		reset |=> (!i_int_pending && i_pcn == '0))
		else $error("seek unit state not cleared by reset");

	a_one_step: assert property (@(posedge clk_sys) disable iff (reset)
		(i_pcn == $past(i_pcn)) || (i_pcn == $past(i_pcn) + 8'd1)
		|| (i_pcn == $past(i_pcn) - 8'd1))
		else $error("head moved more than one cylinder in a cycle");

	a_in_range: assert property (@(posedge clk_sys) disable iff (reset)
		i_pcn < MAX_TRACKS)
		else $error("head position beyond the last cylinder");

	// interrupt only raised once the head has stopped
	a_busy_int: assert property (@(posedge clk_sys) disable iff (reset)
		!(i_busy && i_int_pending))
		else $error("seek busy and interrupt pending at the same time");

endmodule

bind fdc_drive_seek fdc_props i_props (
	.clk_sys       (clk_sys),
	.reset         (reset),
	.i_pcn         (o_pcn),
	.i_busy        (o_busy),
	.i_int_pending (o_int_pending)
);

// ==== testbench/fdc_tb.sv ====
// ==============================
// fdc testbench
// random commands on the host bus,
// checked against a drive model
// ==============================

module fdc_tb;
	timeunit 1ns;
	timeprecision 100ps;

	import fdc_reg_pkg::*;
	import fdc_cmd_pkg::*;

	localparam int CYC_MS = 8;
	localparam int N_ITER = 40;
	// 40 seeks of up to 80 steps at 16 x 9 cycles, plus bus traffic
	localparam int MAX_CYCLE = 600000;

	localparam reg_byte_t MSR_PARAM = reg_byte_t'((1 << MSR_RQM) | (1 << MSR_CB));
	localparam reg_byte_t MSR_REPLY = reg_byte_t'((1 << MSR_RQM) | (1 << MSR_DIO) | (1 << MSR_CB));

	logic        clk_sys = 1'b0;
	logic        reset;
	logic        nrd, nwr, a0;
	reg_byte_t   din, dout;
	logic [1:0]  ready, wp, two_sided;

	cyl_t        m_pcn [2];	// model head position
	logic [1:0]  m_pend, m_ok;	// model interrupt state
	int          errors = 0;
	int          cycles = 0;
	int unsigned seed;

	fdc_top #(.CYCLES_PER_MS(CYC_MS)) i_fdc_top (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.i_nrd       (nrd),
		.i_nwr       (nwr),
		.i_a0        (a0),
		.i_din       (din),
		.i_ready     (ready),
		.i_wp        (wp),
		.i_two_sided (two_sided),
		.o_dout      (dout)
	);

	always #5 clk_sys = ~clk_sys;

	always @(posedge clk_sys) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLE) begin
			$display("timeout after %0d cycles, the controller never became ready", cycles);
			$display("=== FAIL ===");
			$finish;
		end
	end

	// ==============================
	// compare tasks
	// ==============================
	task automatic check_msr(input reg_byte_t got, input reg_byte_t exp);
		if (got !== exp) begin
			errors++;
			$display("error o_dout (main status) got %h expected %h", got, exp);
		end
	endtask

	task automatic check_result(input reg_byte_t got, input reg_byte_t exp);
		if (got !== exp) begin
			errors++;
			$display("error o_dout (result) got %h expected %h", got, exp);
		end
	endtask

	task automatic check_cyl(input cyl_t got, input cyl_t exp);
		if (got !== exp) begin
			errors++;
			$display("error o_dout (pcn) got %h expected %h", got, exp);
		end
	endtask

	// ==============================
	// host bus access
	// ==============================
	task automatic bus_read(input logic addr, output reg_byte_t data);
		@(posedge clk_sys);
		a0  <= addr;
		nrd <= 1'b0;
		repeat (4) @(posedge clk_sys);
		nrd <= 1'b1;
		@(negedge clk_sys);
		data = dout;	// loaded three edges after the pins
		repeat (4) @(posedge clk_sys);
	endtask

	task automatic bus_write(input logic addr, input reg_byte_t data);
		@(posedge clk_sys);
		a0  <= addr;
		din <= data;
		nwr <= 1'b0;
		repeat (4) @(posedge clk_sys);
		nwr <= 1'b1;
		repeat (4) @(posedge clk_sys);
	endtask

	task automatic wait_rqm(output reg_byte_t msr);
		do
			bus_read(1'b0, msr);
		while (!msr[MSR_RQM]);
	endtask

	task automatic send_byte(input reg_byte_t data, input reg_byte_t exp_msr);
		reg_byte_t msr;
		wait_rqm(msr);
		check_msr(msr, exp_msr);
		bus_write(1'b1, data);
	endtask

	task automatic get_byte(output reg_byte_t data);
		reg_byte_t msr;
		wait_rqm(msr);
		check_msr(msr, MSR_REPLY);
		bus_read(1'b1, data);
	endtask

	function automatic logic is_kept(input reg_byte_t op);
		if (op[7:5] != 3'b000)
			return 1'b0;
		case (op[4:0])
			5'h03, 5'h04, 5'h07, 5'h08, 5'h0F: return 1'b1;
			default: return 1'b0;
		endcase
	endfunction

	// ==============================
	// commands with model updates
	// ==============================
	task automatic do_specify(input step_rate_t srt);
		send_byte({3'b000, OP_SPECIFY}, MSR_RESET);
		m_pend = 2'b00;
		send_byte({srt, 4'hF}, MSR_PARAM);
		send_byte(8'h02, MSR_PARAM);
	endtask

	// seek or recalibrate, busy checked when the head must move
	task automatic do_seek(input logic recal, input drive_t d, input cyl_t cyl);
		reg_byte_t msr;
		logic      moves;
		send_byte({3'b000, recal ? OP_RECALIBRATE : OP_SEEK}, MSR_RESET);
		m_pend = 2'b00;
		send_byte({7'b0, d}, MSR_PARAM);
		if (!recal)
			send_byte(cyl, MSR_PARAM);
		moves = 1'b0;
		if ((ready[d] && cyl < 8'd80) || cyl == 8'd0) begin
			moves    = (m_pcn[d] != cyl);
			m_pcn[d] = cyl;
			m_ok[d]  = ready[d];
		end else begin
			m_ok[d] = 1'b0;	// rejected, head stays
		end
		m_pend[d] = 1'b1;
		if (moves) begin
			bus_read(1'b0, msr);
			check_msr(msr, reg_byte_t'(1 << (MSR_D0B + d)));
		end
	endtask

	task automatic do_sense_int();
		reg_byte_t st0, pcn_byte;
		drive_t    d;
		send_byte({3'b000, OP_SENSE_INT}, MSR_RESET);
		get_byte(st0);
		if (m_pend == 2'b00) begin
			check_result(st0, ST0_INVALID);
		end else begin
			d = m_pend[0] ? 1'b0 : 1'b1;	// lowest drive first
			check_result(st0, (m_ok[d] ? ST0_SEEK_END : ST0_SEEK_FAIL) | reg_byte_t'(d));
			get_byte(pcn_byte);
			check_cyl(cyl_t'(pcn_byte), m_pcn[d]);
			m_pend[d] = 1'b0;
		end
	endtask

	task automatic do_sense_drive(input drive_t d, input logic head);
		reg_byte_t st3;
		send_byte({3'b000, OP_SENSE_DRIVE}, MSR_RESET);
		m_pend = 2'b00;
		send_byte({5'b0, head, 1'b0, d}, MSR_PARAM);
		get_byte(st3);
		check_result(st3, {1'b0, wp[d] & ready[d], ready[d], m_pcn[d] == 8'd0,
			two_sided[d], head, 1'b0, d});
	endtask

	task automatic do_invalid();
		reg_byte_t op, res;
		do
			op = reg_byte_t'($urandom);
		while (is_kept(op));
		send_byte(op, MSR_RESET);
		m_pend = 2'b00;
		get_byte(res);
		check_result(res, ST0_INVALID);
	endtask

	// ==============================
	// main sequence
	// ==============================
	initial begin
		reg_byte_t  msr;
		logic [1:0] rdy;
		drive_t     d;
		int         kind;
		seed      = $urandom(32'h4787_b194);
		reset     = 1'b1;
		nrd       = 1'b1;
		nwr       = 1'b1;
		a0        = 1'b0;
		din       = '0;
		ready     = 2'b11;
		wp        = 2'b00;
		two_sided = 2'b00;
		m_pcn[0]  = '0;
		m_pcn[1]  = '0;
		m_pend    = 2'b00;
		m_ok      = 2'b00;
		repeat (3) @(posedge clk_sys);
		reset <= 1'b0;

		bus_read(1'b0, msr);
		check_msr(msr, MSR_RESET);
		do_sense_int();

		for (int i = 0; i < N_ITER; i++) begin
			rdy = 2'($urandom_range(1, 3));	// at least one drive ready
			@(posedge clk_sys);
			ready     <= rdy;
			wp        <= 2'($urandom);
			two_sided <= 2'($urandom);
			@(posedge clk_sys);
			d    = drive_t'($urandom_range(0, 1));
			kind = $urandom_range(0, 4);
			case (kind)
				0, 1: begin
					if (!rdy[d])
						d = ~d;
					do_specify(step_rate_t'($urandom));
					do_seek(1'b0, d, cyl_t'($urandom_range(0, 79)));
					do_sense_int();
				end
				2: begin
					do_seek(1'b0, d, rdy[d] ? cyl_t'($urandom_range(80, 255))
						: cyl_t'($urandom_range(1, 255)));
					do_sense_int();
				end
				3: begin
					do_seek(1'b1, d, '0);
					do_sense_int();
					do_sense_drive(d, 1'($urandom));
				end
				default: begin
					do_seek(1'b0, d, cyl_t'($urandom_range(0, 79)));	// leaves one pending
					do_invalid();
					do_sense_int();	// interrupts were cleared
				end
			endcase
		end

		$display("checks done, %0d errors", errors);
		if (errors == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

// ==== fdc_ctrl.f ====
hdl/fdc_reg_pkg.sv
hdl/fdc_cmd_pkg.sv
hdl/fdc_host_port.sv
hdl/fdc_drive_seek.sv
hdl/fdc_command_fsm.sv
hdl/fdc_top.sv
testbench/fdc_props.sv
testbench/fdc_tb.sv

// ==== Bender.yml ====
package:
  name: fdc_ctrl

sources:
  - files:
      - hdl/fdc_reg_pkg.sv
      - hdl/fdc_cmd_pkg.sv
      - hdl/fdc_host_port.sv
      - hdl/fdc_drive_seek.sv
      - hdl/fdc_command_fsm.sv
      - hdl/fdc_top.sv
  - target: test
    files:
      - testbench/fdc_props.sv
      - testbench/fdc_tb.sv
